/* source/frontend_pkg.sv */
package frontend_pkg;

    // datapath widths
    localparam int xlen        = 32;
    localparam int fetch_width = 2;

    // buffer sizes
    localparam int raw_fifo_depth     = 8;
    localparam int decoded_fifo_depth = 4;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

    // register usage class of one instruction
    typedef enum logic [2:0] {
        reg_type_none = 3'd0,
        reg_type_rw   = 3'd1,
        reg_type_rrw  = 3'd2,
        reg_type_rr   = 3'd3,
        reg_type_bl   = 3'd4
    } reg_type_e;

    // opcode table
    // add.w matches inst[31:15]
    localparam logic [16:0] op_add_w = 17'h00020;

    // addi.w, ld.w and st.w match inst[31:22]
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_w   = 10'h0a6;

    // branches match inst[31:26]
    localparam logic [5:0] op_beq = 6'h16;
    localparam logic [5:0] op_bl  = 6'h15;

    // bl links into r1
    localparam logic [4:0] link_reg = 5'd1;

    // raw instruction as fetched
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_entry_t;

    // decoded instruction handed to the backend
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        reg_type_e       reg_type;
        logic [4:0]      r_reg0;
        logic [4:0]      r_reg1;
        logic [4:0]      w_reg;
    } inst_t;

endpackage

/* source/pc_gen.sv */
`timescale 1ns/1ns

module pc_gen (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  logic                          redirect_i,
    input  logic [frontend_pkg::xlen-1:0] redirect_pc_i,
    output logic [frontend_pkg::xlen-1:0] pc_o,
    output logic [1:0]                    slot_valid_o,
    output logic                          req_o
);
    import frontend_pkg::*;

    logic [xlen-1:0] pc_q;
    logic            slot0_mask_q;
    logic            run_q;

    // no fetch on the first cycle out of reset
    assign req_o = run_q & ~stall_i & ~redirect_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q         <= reset_pc;
            slot0_mask_q <= 1'b0;
            run_q        <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (redirect_i) begin
                // restart at the pair holding the target
                pc_q         <= {redirect_pc_i[xlen-1:3], 3'b000};
                slot0_mask_q <= redirect_pc_i[2];
            end else if (req_o) begin
                pc_q         <= pc_q + xlen'(8);
                slot0_mask_q <= 1'b0;
            end
        end
    end

    assign pc_o = pc_q;

    // odd-word target drops the lower slot
    assign slot_valid_o = {1'b1, ~slot0_mask_q};

endmodule

/* source/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              flush_i,
    input  logic                              req_i,
    input  logic [frontend_pkg::xlen-1:0]     pc_i,
    input  logic [1:0]                        slot_valid_i,
    input  logic [2*frontend_pkg::xlen-1:0]   imem_data_i,
    input  logic                              fifo_ready_i,
    output logic                              ready_o,
    output logic [1:0]                        write_num_o,
    output frontend_pkg::fetch_entry_t [1:0]  write_data_o
);
    import frontend_pkg::*;

    logic                  inflight_q;
    logic [xlen-1:0]       inflight_pc_q;
    logic [1:0]            inflight_mask_q;
    logic                  hold_q;
    logic [1:0]            hold_num_q;
    fetch_entry_t [1:0]    hold_data_q;
    fetch_entry_t          lo_entry;
    fetch_entry_t          hi_entry;
    fetch_entry_t [1:0]    resp_data;
    logic [1:0]            resp_num;
    logic                  park;

    // split the returned pair, lower word at the lower address
    always_comb begin
        lo_entry.pc   = {inflight_pc_q[xlen-1:3], 3'b000};
        lo_entry.inst = imem_data_i[xlen-1:0];
        hi_entry.pc   = {inflight_pc_q[xlen-1:3], 3'b100};
        hi_entry.inst = imem_data_i[2*xlen-1:xlen];
        // compact valid slots toward slot 0
        resp_data[0] = inflight_mask_q[0] ? lo_entry : hi_entry;
        resp_data[1] = hi_entry;
        resp_num     = {&inflight_mask_q, ^inflight_mask_q};
    end

    // response arrives while the FIFO is full
    assign park = inflight_q & ~hold_q & ~fifo_ready_i;

    assign write_data_o = hold_q ? hold_data_q : resp_data;
    assign write_num_o  = !fifo_ready_i ? 2'd0 :
                          hold_q        ? hold_num_q :
                          inflight_q    ? resp_num : 2'd0;
    assign ready_o      = ~hold_q & ~(inflight_q & ~fifo_ready_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inflight_q <= 1'b0;
            hold_q     <= 1'b0;
            hold_num_q <= 2'd0;
        end else if (flush_i) begin
            inflight_q <= 1'b0;
            hold_q     <= 1'b0;
        end else begin
            inflight_q <= req_i;
            if (hold_q) begin
                hold_q <= ~fifo_ready_i;
            end else if (park) begin
                hold_q     <= 1'b1;
                hold_num_q <= resp_num;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            inflight_pc_q   <= pc_i;
            inflight_mask_q <= slot_valid_i;
        end
        if (park) begin
            hold_data_q <= resp_data;
        end
    end

endmodule

/* source/multi_channel_fifo.sv */
`timescale 1ns/1ns

module multi_channel_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 8
) (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           flush_i,
    input  logic     [1:0] write_num_i,
    input  payload_t [1:0] write_data_i,
    output logic           write_ready_o,
    input  logic     [1:0] read_num_i,
    output payload_t [1:0] read_data_o,
    output logic     [1:0] read_valid_o
);
    import frontend_pkg::*;

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem_q [depth];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;
    logic [1:0]       avail_num;
    logic [1:0]       wr_num;
    logic [1:0]       rd_num;

    // room for a full pair
    assign write_ready_o = (cnt_w'(depth) - count_q) >= cnt_w'(2);

    // occupancy capped at two
    assign avail_num    = (count_q >= cnt_w'(2)) ? 2'd2 : count_q[1:0];
    assign read_valid_o = {avail_num[1], avail_num[1] | avail_num[0]};

    // accepted counts this cycle
    assign wr_num = write_ready_o ? write_num_i : 2'd0;
    assign rd_num = (read_num_i <= avail_num) ? read_num_i : 2'd0;

    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            read_data_o[i] = mem_q[rd_ptr_q + ptr_w'(i)];
        end
    end

    // storage, pointers wrap on their own width
    always_ff @(posedge clk) begin
        for (int i = 0; i < fetch_width; i++) begin
            if (i < int'(wr_num)) begin
                mem_q[wr_ptr_q + ptr_w'(i)] <= write_data_i[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // flush wins over a same-cycle write or read
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + ptr_w'(wr_num);
            rd_ptr_q <= rd_ptr_q + ptr_w'(rd_num);
            count_q  <= count_q + cnt_w'(wr_num) - cnt_w'(rd_num);
        end
    end

endmodule

/* source/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder (
    input  frontend_pkg::fetch_entry_t entry_i,
    output frontend_pkg::inst_t        inst_o
);
    import frontend_pkg::*;

    reg_type_e  reg_type;
    logic [4:0] rd;
    logic [4:0] rj;
    logic [4:0] rk;

    assign rd = entry_i.inst[4:0];
    assign rj = entry_i.inst[9:5];
    assign rk = entry_i.inst[14:10];

    // opcode match, unknown encodings fall to none
    always_comb begin
        if (entry_i.inst[31:15] == op_add_w) begin
            reg_type = reg_type_rrw;
        end else if (entry_i.inst[31:22] == op_addi_w) begin
            reg_type = reg_type_rw;
        end else if (entry_i.inst[31:22] == op_ld_w) begin
            reg_type = reg_type_rw;
        end else if (entry_i.inst[31:22] == op_st_w) begin
            reg_type = reg_type_rr;
        end else if (entry_i.inst[31:26] == op_beq) begin
            reg_type = reg_type_rr;
        end else if (entry_i.inst[31:26] == op_bl) begin
            reg_type = reg_type_bl;
        end else begin
            reg_type = reg_type_none;
        end
    end

    // register extraction per class
    always_comb begin
        inst_o.pc       = entry_i.pc;
        inst_o.inst     = entry_i.inst;
        inst_o.reg_type = reg_type;
        inst_o.r_reg0   = 5'd0;
        inst_o.r_reg1   = 5'd0;
        inst_o.w_reg    = 5'd0;
        case (reg_type)
            reg_type_rw: begin
                inst_o.r_reg1 = rj;
                inst_o.w_reg  = rd;
            end
            reg_type_rrw: begin
                inst_o.r_reg0 = rk;
                inst_o.r_reg1 = rj;
                inst_o.w_reg  = rd;
            end
            reg_type_rr: begin
                // store data and branch compare sit in rd
                inst_o.r_reg0 = rd;
                inst_o.r_reg1 = rj;
            end
            reg_type_bl: begin
                inst_o.w_reg = link_reg;
            end
            default: begin
                inst_o.w_reg = 5'd0;
            end
        endcase
    end

endmodule

/* source/frontend.sv */
`timescale 1ns/1ns

module frontend (
    input  logic                            clk,
    input  logic                            rst_n_i,
    output logic                            imem_req_o,
    output logic [frontend_pkg::xlen-1:0]   imem_addr_o,
    input  logic [2*frontend_pkg::xlen-1:0] imem_data_i,
    input  logic                            redirect_i,
    input  logic [frontend_pkg::xlen-1:0]   redirect_pc_i,
    output frontend_pkg::inst_t [1:0]       inst_o,
    output logic [1:0]                      inst_valid_o,
    input  logic [1:0]                      issue_num_i,
    input  logic                            backend_stall_i
);
    import frontend_pkg::*;

    logic [xlen-1:0]    fetch_pc;
    logic [1:0]         fetch_slot_valid;
    logic               fetch_req;
    logic               fetch_ready;
    logic               raw_ready;
    logic [1:0]         raw_write_num;
    fetch_entry_t [1:0] raw_write_data;
    fetch_entry_t [1:0] raw_read_data;
    logic [1:0]         raw_valid;
    logic               decoded_ready;
    inst_t [1:0]        dec_inst;
    logic [1:0]         move_num;
    logic [1:0]         deliver_num;

    pc_gen u_pc_gen (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (~fetch_ready),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .pc_o          (fetch_pc),
        .slot_valid_o  (fetch_slot_valid),
        .req_o         (fetch_req)
    );

    assign imem_req_o  = fetch_req;
    assign imem_addr_o = fetch_pc;

    fetch_stage u_fetch_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (redirect_i),
        .req_i        (fetch_req),
        .pc_i         (fetch_pc),
        .slot_valid_i (fetch_slot_valid),
        .imem_data_i  (imem_data_i),
        .fifo_ready_i (raw_ready),
        .ready_o      (fetch_ready),
        .write_num_o  (raw_write_num),
        .write_data_o (raw_write_data)
    );

    // whole raw pair moves only when the decoded FIFO takes two
    assign move_num = decoded_ready ? {raw_valid[1], raw_valid[0] & ~raw_valid[1]} : 2'd0;

    multi_channel_fifo #(
        .payload_t (fetch_entry_t),
        .depth     (raw_fifo_depth)
    ) raw_fifo (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (redirect_i),
        .write_num_i   (raw_write_num),
        .write_data_i  (raw_write_data),
        .write_ready_o (raw_ready),
        .read_num_i    (move_num),
        .read_data_o   (raw_read_data),
        .read_valid_o  (raw_valid)
    );

    inst_decoder u_decoder_0 (
        .entry_i (raw_read_data[0]),
        .inst_o  (dec_inst[0])
    );

    inst_decoder u_decoder_1 (
        .entry_i (raw_read_data[1]),
        .inst_o  (dec_inst[1])
    );

    assign deliver_num = backend_stall_i ? 2'd0 : issue_num_i;

    multi_channel_fifo #(
        .payload_t (inst_t),
        .depth     (decoded_fifo_depth)
    ) decoded_fifo (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (redirect_i),
        .write_num_i   (move_num),
        .write_data_i  (dec_inst),
        .write_ready_o (decoded_ready),
        .read_num_i    (deliver_num),
        .read_data_o   (inst_o),
        .read_valid_o  (inst_valid_o)
    );

endmodule

/* dv/frontend_sva.sv */
`timescale 1ns/1ns

module frontend_sva (
    input logic       clk,
    input logic       rst_n_i,
    input logic       req_i,
    input logic [1:0] valid_i,
    input logic       raw_ready_i
);
    int fail_count = 0;

    // slot 1 never valid without slot 0
    valid_thermometer: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_i != 2'b10)
        else begin
            fail_count++;
            $error("inst_valid_o not thermometer coded");
        end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n_i |-> (valid_i == 2'b00) && !req_i)
        else begin
            fail_count++;
            $error("outputs active during reset");
        end

    // response meeting a full raw FIFO blocks the next strobe
    strobe_rate: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_i |=> raw_ready_i || !req_i)
        else begin
            fail_count++;
            $error("strobe while the previous response was refused");
        end

endmodule

bind frontend frontend_sva u_frontend_sva (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_i       (imem_req_o),
    .valid_i     (inst_valid_o),
    .raw_ready_i (raw_ready)
);

/* dv/frontend_tb.sv */
`timescale 1ns/1ns

module frontend_tb;
    import frontend_pkg::*;

    localparam int clk_period     = 40;
    localparam int redirect_count = 12;
    // reset, first fetch, streaming cap, back-pressure, redirects, margin
    localparam int budget_cycles  = 3 + 20 + 600 + 400 + redirect_count * 81 + 200;

    logic        clk;
    logic        rst_n_i;
    logic        imem_req_o;
    logic [31:0] imem_addr_o;
    logic [63:0] imem_data_i;
    logic        redirect_i;
    logic [31:0] redirect_pc_i;
    inst_t [1:0] inst_o;
    logic [1:0]  inst_valid_o;
    logic [1:0]  issue_num_i;
    logic        backend_stall_i;
    integer      seed;
    int          errors = 0;
    int          checks = 0;
    int          delivered = 0;
    int          landed = 0;
    int          class_seen [7];
    logic [31:0] exp_pc = reset_pc;
    logic [31:0] target_pc;
    logic        awaiting_target = 1'b0;
    logic        mem_req_seen = 1'b0;
    logic [31:0] mem_addr_seen;

    frontend u_frontend (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(budget_cycles * clk_period);
        $display("watchdog timeout after %0d cycles, run did not finish", budget_cycles);
        $display("Simulation failed");
        $finish;
    end

    // hashed word per address, spread over six classes and an unknown encoding
    function automatic logic [31:0] mix_word(input logic [31:0] addr, output int cls);
        logic [31:0] h;
        h = addr * 32'h9e37_79b9;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        h = h ^ (h >> 13);
        cls = int'(h[31:16]) % 7;
        case (cls)
            0: return {17'h00020, h[14:0]};
            1: return {10'h00a, h[21:0]};
            2: return {10'h0a2, h[21:0]};
            3: return {10'h0a6, h[21:0]};
            4: return {6'h16, h[25:0]};
            5: return {6'h15, h[25:0]};
            default: return {6'h3e, h[25:0]};
        endcase
    endfunction

    function automatic inst_t ref_inst(input logic [31:0] pc, output int cls);
        inst_t r;
        r.pc = pc;
        r.inst = mix_word(pc, cls);
        r.reg_type = reg_type_none;
        r.r_reg0 = 5'd0;
        r.r_reg1 = 5'd0;
        r.w_reg = 5'd0;
        case (cls)
            0: begin
                r.reg_type = reg_type_rrw;
                r.r_reg0 = r.inst[14:10];
                r.r_reg1 = r.inst[9:5];
                r.w_reg = r.inst[4:0];
            end
            1, 2: begin
                r.reg_type = reg_type_rw;
                r.r_reg1 = r.inst[9:5];
                r.w_reg = r.inst[4:0];
            end
            3, 4: begin
                r.reg_type = reg_type_rr;
                r.r_reg0 = r.inst[4:0];
                r.r_reg1 = r.inst[9:5];
            end
            5: begin
                r.reg_type = reg_type_bl;
                r.w_reg = 5'd1;
            end
            default: r.reg_type = reg_type_none;
        endcase
        return r;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // memory answers each strobe during the following cycle
    always @(negedge clk) begin
        mem_req_seen = imem_req_o;
        mem_addr_seen = imem_addr_o;
    end

    always @(posedge clk) begin
        int unused_cls;
        #5;
        if (mem_req_seen) begin
            imem_data_i = {mix_word(mem_addr_seen + 32'd4, unused_cls),
                           mix_word(mem_addr_seen, unused_cls)};
        end
    end

    // compare every slot the backend takes
    always @(negedge clk) begin
        inst_t exp;
        int cls;
        if (rst_n_i && redirect_i) begin
            exp_pc = redirect_pc_i;
            target_pc = redirect_pc_i;
            awaiting_target = 1'b1;
        end else if (rst_n_i && !backend_stall_i) begin
            for (int i = 0; i < 2; i++) begin
                if (i < int'(issue_num_i)) begin
                    exp = ref_inst(exp_pc, cls);
                    check_value("slot valid", 64'(inst_valid_o[i]), 64'd1);
                    check_value("pc", 64'(inst_o[i].pc), 64'(exp.pc));
                    check_value("inst", 64'(inst_o[i].inst), 64'(exp.inst));
                    check_value("reg_type", 64'(inst_o[i].reg_type), 64'(exp.reg_type));
                    check_value("r_reg0", 64'(inst_o[i].r_reg0), 64'(exp.r_reg0));
                    check_value("r_reg1", 64'(inst_o[i].r_reg1), 64'(exp.r_reg1));
                    check_value("w_reg", 64'(inst_o[i].w_reg), 64'(exp.w_reg));
                    if (awaiting_target) begin
                        check_value("pc after redirect", 64'(inst_o[i].pc), 64'(target_pc));
                        awaiting_target = 1'b0;
                        landed++;
                    end
                    class_seen[cls]++;
                    delivered++;
                    exp_pc = exp_pc + 32'd4;
                end
            end
        end
    end

    task automatic drive_cycle(input bit random_mode);
        logic [31:0] rnd;
        logic [1:0]  vc;
        @(posedge clk);
        #5;
        redirect_i = 1'b0;
        vc = {1'b0, inst_valid_o[0]} + {1'b0, inst_valid_o[1]};
        backend_stall_i = 1'b0;
        issue_num_i = vc;
        if (random_mode) begin
            rnd = $random(seed);
            backend_stall_i = rnd[2];
            issue_num_i = (rnd[1:0] > vc) ? vc : rnd[1:0];
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] target;
        int          err_before;
        int          start;
        int          cyc;
        seed = 32'hb78c_c23a;
        rst_n_i = 1'b0;
        imem_data_i = '0;
        redirect_i = 1'b0;
        redirect_pc_i = '0;
        issue_num_i = 2'd0;
        backend_stall_i = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("inst_valid_o in reset", 64'(inst_valid_o), 64'd0);
            check_value("imem_req_o in reset", 64'(imem_req_o), 64'd0);
        end
        @(posedge clk);
        #5 rst_n_i = 1'b1;
        cyc = 0;
        while (!inst_valid_o[0] && cyc < 20) begin
            @(posedge clk);
            #5 cyc++;
        end
        if (!inst_valid_o[0]) begin
            errors++;
            $display("no instruction was delivered after reset");
        end
        check_value("first pc", 64'(inst_o[0].pc), 64'(reset_pc));
        report_test("reset", 0);

        err_before = errors;
        start = delivered;
        cyc = 0;
        while (delivered - start < 200 && cyc < 600) begin
            drive_cycle(1'b0);
            cyc++;
        end
        if (delivered - start < 200) begin
            errors++;
            $display("streaming delivered only %0d instructions", delivered - start);
        end
        report_test("streaming", err_before);

        err_before = errors;
        for (int c = 0; c < 7; c++) begin
            if (class_seen[c] == 0) begin
                errors++;
                $display("instruction class %0d was never observed", c);
            end
        end
        report_test("decode rule", err_before);

        err_before = errors;
        start = delivered;
        repeat (400) drive_cycle(1'b1);
        if (delivered == start) begin
            errors++;
            $display("back-pressure phase delivered no instructions");
        end
        report_test("back-pressure", err_before);

        err_before = errors;
        for (int k = 0; k < redirect_count; k++) begin
            rnd = $random(seed);
            repeat (5 + int'(rnd[3:0])) drive_cycle(1'b1);
            // alternate even-word and odd-word targets
            target = {reset_pc[31:20], rnd[26:10], k[0], 2'b00};
            start = landed;
            @(posedge clk);
            #5;
            redirect_i = 1'b1;
            redirect_pc_i = target;
            issue_num_i = 2'd0;
            cyc = 0;
            while (landed == start && cyc < 60) begin
                drive_cycle(1'b1);
                cyc++;
            end
            if (landed == start) begin
                errors++;
                $display("redirect to %h was never delivered", target);
            end
        end
        repeat (20) drive_cycle(1'b1);
        report_test("redirect", err_before);

        cyc = u_frontend.u_frontend_sva.fail_count;
        $display("tests: 5, checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, cyc);
        if (errors == 0 && cyc == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* src.f */
source/frontend_pkg.sv
source/pc_gen.sv
source/fetch_stage.sv
source/multi_channel_fifo.sv
source/inst_decoder.sv
source/frontend.sv
dv/frontend_sva.sv
dv/frontend_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module frontend_tb -f src.f -o sim_frontend

out=$(./obj_dir/sim_frontend +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
else
    exit 1
fi
